/* tb.f */
+incdir+.
fetch_pkg.sv
fetch_line_receiver.sv
inst_queue.sv
issue_pair_checker.sv
fetch_stage.sv
tb_fetch_stage.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_fetch_stage -o sim_fetch_stage
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/sim_fetch_stage)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Simulation PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* tb_fetch_tests.svh */
task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
        error_count++;
        $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
endtask

function automatic fetch_pkg::word_t r_inst(input logic [5:0] op, input logic [4:0] rs,
        input logic [4:0] rt, input logic [4:0] rd, input logic [5:0] func);
    fetch_pkg::inst_word_u w;
    w = '0;
    w.r_fmt.op   = op;
    w.r_fmt.rs   = rs;
    w.r_fmt.rt   = rt;
    w.r_fmt.rd   = rd;
    w.r_fmt.func = func;
    return w;
endfunction

function automatic fetch_pkg::word_t i_inst(input logic [5:0] op, input logic [4:0] rs,
        input logic [4:0] rt, input logic [15:0] imm);
    fetch_pkg::inst_word_u w;
    w.i_fmt.op  = op;
    w.i_fmt.rs  = rs;
    w.i_fmt.rt  = rt;
    w.i_fmt.imm = imm;
    return w;
endfunction

// addu sources in r16..r31 stay clear of the destinations
function automatic fetch_pkg::word_t alu_inst(input logic [4:0] rd);
    return r_inst(fetch_pkg::OP_SPECIAL, 5'(16 + $urandom % 16), 5'(16 + $urandom % 16), rd,
                  fetch_pkg::FN_ADDU);
endfunction

task automatic fill_alu(input int count);
    for (int i = 0; i < count; i++) begin
        line_buf[i] = alu_inst(5'(i + 1));
    end
endtask

task automatic load_cache(input int count);
    next_count = CW'(count);
    for (int i = 0; i < LINE_WORDS; i++) begin
        next_data[i] = (i < count) ? line_buf[i] : '0;
    end
endtask

task automatic fetch_addr(input fetch_pkg::pc_t addr, input logic fault);
    @(posedge clk);
    pc_valid <= 1'b1;
    pc       <= addr;
    pc_fault <= fault;
    @(negedge clk);
    while (!pc_ready) begin
        @(negedge clk);
    end
    @(posedge clk);
    pc_valid <= 1'b0;
    pc_fault <= 1'b0;
endtask

// entries are visible one edge after the strobe
task automatic wait_line();
    @(negedge clk);
    while (!line_ok) begin
        @(negedge clk);
    end
    @(negedge clk);
endtask

task automatic fetch_line(input fetch_pkg::pc_t addr, input int count);
    load_cache(count);
    for (int i = 0; i < count; i++) begin
        exp_inst.push_back(line_buf[i]);
        exp_pc.push_back(addr + 32'(4 * i));
        exp_fault.push_back(1'b0);
    end
    fetch_addr(addr, 1'b0);
    wait_line();
endtask

task automatic expect_pair(input string name, input logic dual);
    fetch_pkg::word_t inst0;
    fetch_pkg::pc_t   pc0;
    logic             fault0;
    fetch_pkg::word_t inst1;
    fetch_pkg::pc_t   pc1;
    logic             fault1;
    @(negedge clk);
    while (!issue_valid) begin
        @(negedge clk);
    end
    inst0  = exp_inst.pop_front();
    pc0    = exp_pc.pop_front();
    fault0 = exp_fault.pop_front();
    inst1  = '0;
    pc1    = '0;
    fault1 = 1'b0;
    if (dual) begin
        inst1  = exp_inst.pop_front();
        pc1    = exp_pc.pop_front();
        fault1 = exp_fault.pop_front();
    end
    compare({name, " issue_dual"}, 32'(dual), 32'(issue_dual));
    compare({name, " slot0_inst"}, inst0, slot0_inst);
    compare({name, " slot0_pc"}, pc0, slot0_pc);
    compare({name, " slot0_fault"}, 32'(fault0), 32'(slot0_fault));
    compare({name, " slot1_inst"}, inst1, slot1_inst);
    compare({name, " slot1_pc"}, pc1, slot1_pc);
    compare({name, " slot1_fault"}, 32'(fault1), 32'(slot1_fault));
    @(posedge clk);
    issue_ready <= 1'b1;
    @(posedge clk);
    issue_ready <= 1'b0;
endtask

task automatic drain_pairs(input string name);
    while (exp_inst.size() >= 2) begin
        expect_pair(name, 1'b1);
    end
endtask

task automatic test_reset();
    @(negedge clk);
    compare("reset issue_valid", 32'(1'b0), 32'(issue_valid));
    compare("reset pc_ready", 32'(1'b1), 32'(pc_ready));
    compare("reset pc_offset", 32'(4), 32'(pc_offset));
endtask

task automatic test_full_line();
    fill_alu(8);
    fetch_line(32'h0000_1000, 8);
    drain_pairs("full_line");
    compare("full_line pc_offset", 32'(32), 32'(pc_offset));
endtask

task automatic test_pairing();
    // beq held back and then leads its own pair
    line_buf[0] = alu_inst(5'd1);
    line_buf[1] = i_inst(fetch_pkg::OP_BEQ, 5'd2, 5'd3, 16'h0004);
    line_buf[2] = alu_inst(5'd4);
    fetch_line(32'h0000_3000, 3);
    expect_pair("branch_second", 1'b0);
    expect_pair("branch_first", 1'b1);
    line_buf[0] = r_inst(fetch_pkg::OP_SPECIAL, 5'd8, 5'd9, 5'd0, fetch_pkg::FN_MULT);
    line_buf[1] = r_inst(fetch_pkg::OP_SPECIAL, 5'd10, 5'd11, 5'd0, fetch_pkg::FN_DIV);
    line_buf[2] = alu_inst(5'd4);
    fetch_line(32'h0000_3100, 3);
    expect_pair("mult_div", 1'b0);
    expect_pair("div_alu", 1'b1);
    line_buf[0] = i_inst(fetch_pkg::OP_LW, 5'd29, 5'd5, 16'h0010);
    line_buf[1] = r_inst(fetch_pkg::OP_SPECIAL, 5'd5, 5'd6, 5'd7, fetch_pkg::FN_ADDU);
    line_buf[2] = alu_inst(5'd4);
    fetch_line(32'h0000_3200, 3);
    expect_pair("load_use", 1'b0);
    expect_pair("after_load_use", 1'b1);
    // r0 never carries a result
    line_buf[0] = i_inst(fetch_pkg::OP_LW, 5'd29, 5'd0, 16'h0020);
    line_buf[1] = r_inst(fetch_pkg::OP_SPECIAL, 5'd0, 5'd0, 5'd7, fetch_pkg::FN_ADDU);
    fetch_line(32'h0000_3300, 2);
    expect_pair("load_r0", 1'b1);
endtask

task automatic test_fault();
    for (int i = 0; i < 2; i++) begin
        exp_inst.push_back('0);
        exp_pc.push_back(32'h0000_4000 + 32'(4 * i));
        exp_fault.push_back(1'b1);
    end
    fetch_addr(32'h0000_4000, 1'b1);
    expect_pair("fault", 1'b1);
    // offset still set by the two-word line before
    compare("fault pc_offset", 32'(2 * 4), 32'(pc_offset));
endtask

task automatic check_held(input string name, input fetch_pkg::word_t inst0,
        input fetch_pkg::pc_t pc0, input fetch_pkg::word_t inst1);
    compare({name, " slot0_inst"}, inst0, slot0_inst);
    compare({name, " slot0_pc"}, pc0, slot0_pc);
    compare({name, " slot1_inst"}, inst1, slot1_inst);
endtask

task automatic test_backpressure();
    fill_alu(6);
    fetch_line(32'h0000_2000, 6);
    repeat (4) begin
        @(negedge clk);
        check_held("hold", exp_inst[0], exp_pc[0], exp_inst[1]);
    end
    fill_alu(8);
    fetch_line(32'h0000_2018, 8);
    check_held("hold_second_line", exp_inst[0], exp_pc[0], exp_inst[1]);
    compare("backpressure pc_ready", 32'(1'b0), 32'(pc_ready));
    drain_pairs("backpressure_drain");
    @(negedge clk);
    compare("backpressure drained issue_valid", 32'(1'b0), 32'(issue_valid));
endtask

task automatic test_flush();
    fill_alu(2);
    fetch_line(32'h0000_5000, 2);
    fill_alu(4);
    load_cache(4);
    fetch_addr(32'h0000_5100, 1'b0);
    @(posedge clk);
    flush <= 1'b1;
    @(negedge clk);
    compare("flush issue_valid", 32'(1'b0), 32'(issue_valid));
    @(posedge clk);
    flush <= 1'b0;
    wait_line();
    exp_inst.delete();
    exp_pc.delete();
    exp_fault.delete();
    repeat (4) begin
        @(negedge clk);
        compare("after_flush issue_valid", 32'(1'b0), 32'(issue_valid));
    end
    compare("after_flush pc_offset", 32'(4), 32'(pc_offset));
    fill_alu(4);
    fetch_line(32'h0000_5200, 4);
    drain_pairs("refetch");
    compare("refetch pc_offset", 32'(16), 32'(pc_offset));
endtask

/* tb_fetch_stage.sv */
module tb_fetch_stage;

    localparam int LINE_WORDS      = 8;
    localparam int QUEUE_DEPTH     = 16;
    localparam int CW              = $clog2(LINE_WORDS + 1);
    localparam int TEST_COUNT      = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int TIMEOUT_CYCLES  = 16 + TEST_COUNT * CYCLES_PER_TEST;

    logic                              clk;
    logic                              reset;
    logic                              flush;
    logic                              pc_valid;
    fetch_pkg::pc_t                    pc;
    logic                              pc_fault;
    logic                              pc_ready;
    logic [5:0]                        pc_offset;
    logic                              line_ok    = 1'b0;
    logic [CW-1:0]                     line_count = '0;
    fetch_pkg::word_t [LINE_WORDS-1:0] line_data  = '0;
    logic                              issue_ready;
    logic                              issue_valid;
    logic                              issue_dual;
    fetch_pkg::word_t                  slot0_inst;
    fetch_pkg::pc_t                    slot0_pc;
    logic                              slot0_fault;
    fetch_pkg::word_t                  slot1_inst;
    fetch_pkg::pc_t                    slot1_pc;
    logic                              slot1_fault;

    // cache model
    logic [CW-1:0]                     next_count;
    fetch_pkg::word_t [LINE_WORDS-1:0] next_data;
    int                                cache_wait  = 0;
    fetch_pkg::word_t                  line_buf [LINE_WORDS];

    // expected queue contents, oldest first
    fetch_pkg::word_t exp_inst  [$];
    fetch_pkg::pc_t   exp_pc    [$];
    logic             exp_fault [$];

    int check_count;
    int error_count;
    int cycle_count = 0;

    fetch_stage #(
        .LINE_WORDS (LINE_WORDS),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_fetch_stage (
        .*
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // answers each accepted line fetch three cycles later
    always @(posedge clk) begin
        line_ok <= 1'b0;
        if (reset) begin
            cache_wait <= 0;
        end else if (pc_valid && pc_ready && !pc_fault) begin
            cache_wait <= 3;
        end else if (cache_wait == 1) begin
            cache_wait <= 0;
            line_ok    <= 1'b1;
            line_count <= next_count;
            line_data  <= next_data;
        end else if (cache_wait > 0) begin
            cache_wait <= cache_wait - 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout at cycle %0d, %0d checks run, %0d errors", cycle_count,
                     check_count, error_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    `include "tb_fetch_tests.svh"

    initial begin
        reset       <= 1'b1;
        flush       <= 1'b0;
        pc_valid    <= 1'b0;
        pc          <= '0;
        pc_fault    <= 1'b0;
        issue_ready <= 1'b0;
        next_count  = '0;
        next_data   = '0;
        check_count = 0;
        error_count = 0;
        void'($urandom(18352));
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        test_reset();
        test_full_line();
        test_pairing();
        test_fault();
        test_backpressure();
        test_flush();

        repeat (4) @(posedge clk);
        $display("%0d checks run, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* fetch_stage.sv */
module fetch_stage #(
    parameter int LINE_WORDS  = 8,
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  flush,
    // PC stage
    input  logic                                  pc_valid,
    input  fetch_pkg::pc_t                        pc,
    input  logic                                  pc_fault,
    output logic                                  pc_ready,
    output logic [5:0]                            pc_offset,
    // icache response
    input  logic                                  line_ok,
    input  logic [$clog2(LINE_WORDS + 1)-1:0]     line_count,
    input  fetch_pkg::word_t [LINE_WORDS-1:0]     line_data,
    // decode
    input  logic                                  issue_ready,
    output logic                                  issue_valid,
    output logic                                  issue_dual,
    output fetch_pkg::word_t                      slot0_inst,
    output fetch_pkg::pc_t                        slot0_pc,
    output logic                                  slot0_fault,
    output fetch_pkg::word_t                      slot1_inst,
    output fetch_pkg::pc_t                        slot1_pc,
    output logic                                  slot1_fault
);

    logic                                  push_en;
    logic [$clog2(LINE_WORDS + 1)-1:0]     push_count;
    fetch_pkg::word_t [LINE_WORDS-1:0]     push_data;
    fetch_pkg::pc_t                        push_pc;
    logic                                  push_fault;
    logic                                  has_room;

    logic                                  head_valid;
    fetch_pkg::word_t                      head0_inst;
    fetch_pkg::pc_t                        head0_pc;
    logic                                  head0_fault;
    fetch_pkg::word_t                      head1_inst;
    fetch_pkg::pc_t                        head1_pc;
    logic                                  head1_fault;
    logic                                  pop_en;
    logic                                  pop_two;

    // port names match the net names throughout
    fetch_line_receiver #(
        .LINE_WORDS(LINE_WORDS)
    ) i_fetch_line_receiver (
        .*
    );

    inst_queue #(
        .LINE_WORDS (LINE_WORDS),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_inst_queue (
        .*
    );

    issue_pair_checker i_issue_pair_checker (
        .*
    );

endmodule

/* issue_pair_checker.sv */
module issue_pair_checker (
    input  logic             head_valid,
    input  fetch_pkg::word_t head0_inst,
    input  fetch_pkg::pc_t   head0_pc,
    input  logic             head0_fault,
    input  fetch_pkg::word_t head1_inst,
    input  fetch_pkg::pc_t   head1_pc,
    input  logic             head1_fault,
    input  logic             issue_ready,
    output logic             pop_en,
    output logic             pop_two,
    output logic             issue_valid,
    output logic             issue_dual,
    output fetch_pkg::word_t slot0_inst,
    output fetch_pkg::pc_t   slot0_pc,
    output logic             slot0_fault,
    output fetch_pkg::word_t slot1_inst,
    output fetch_pkg::pc_t   slot1_pc,
    output logic             slot1_fault
);

    function automatic logic is_branch(fetch_pkg::inst_word_u w);
        case (w.j_fmt.op)
            // bltz, bgez, bltzal, bgezal
            fetch_pkg::OP_REGIMM: return w.i_fmt.rt[3:1] == 3'b000;
            fetch_pkg::OP_BEQ,
            fetch_pkg::OP_BNE,
            fetch_pkg::OP_BLEZ,
            fetch_pkg::OP_BGTZ,
            fetch_pkg::OP_J,
            fetch_pkg::OP_JAL: return 1'b1;
            fetch_pkg::OP_SPECIAL: return w.r_fmt.func inside {fetch_pkg::FN_JR, fetch_pkg::FN_JALR};
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic is_muldiv(fetch_pkg::inst_word_u w);
        case (w.r_fmt.op)
            fetch_pkg::OP_SPECIAL: return w.r_fmt.func inside {fetch_pkg::FN_MULT,
                fetch_pkg::FN_MULTU, fetch_pkg::FN_DIV, fetch_pkg::FN_DIVU};
            fetch_pkg::OP_SPECIAL2: return w.r_fmt.func == fetch_pkg::FN_MUL;
            default: return 1'b0;
        endcase
    endfunction

    // result not ready in time for a same-cycle partner
    function automatic logic is_load(fetch_pkg::inst_word_u w);
        case (w.r_fmt.op)
            fetch_pkg::OP_LB,
            fetch_pkg::OP_LBU,
            fetch_pkg::OP_LH,
            fetch_pkg::OP_LHU,
            fetch_pkg::OP_LW,
            fetch_pkg::OP_LWL,
            fetch_pkg::OP_LWR: return 1'b1;
            fetch_pkg::OP_COP0: return w.r_fmt.rs == fetch_pkg::COP0_MF;
            fetch_pkg::OP_SPECIAL: return w.r_fmt.func inside {fetch_pkg::FN_MFHI,
                fetch_pkg::FN_MFLO};
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic reads_rs(fetch_pkg::inst_word_u w);
        case (w.r_fmt.op)
            // alu 0x20..0x2f, mult/div 0x18..0x1b
            fetch_pkg::OP_SPECIAL: return w.r_fmt.func[5] || (w.r_fmt.func[5:3] == 3'b011) ||
                (w.r_fmt.func inside {fetch_pkg::FN_SLLV, fetch_pkg::FN_SRLV,
                fetch_pkg::FN_SRAV, fetch_pkg::FN_JR, fetch_pkg::FN_JALR,
                fetch_pkg::FN_MTHI, fetch_pkg::FN_MTLO});
            fetch_pkg::OP_REGIMM,
            fetch_pkg::OP_BEQ,
            fetch_pkg::OP_BNE,
            fetch_pkg::OP_BLEZ,
            fetch_pkg::OP_BGTZ: return 1'b1;
            fetch_pkg::OP_SPECIAL2: return w.r_fmt.func == fetch_pkg::FN_MUL;
            // immediate alu ops, then loads and stores
            default: return ((w.i_fmt.op[5:3] == 3'b001) && (w.i_fmt.op != fetch_pkg::OP_LUI)) ||
                (w.i_fmt.op[5:4] == 2'b10);
        endcase
    endfunction

    function automatic logic reads_rt(fetch_pkg::inst_word_u w);
        case (w.r_fmt.op)
            fetch_pkg::OP_SPECIAL: return w.r_fmt.func[5] || (w.r_fmt.func[5:3] == 3'b011) ||
                (w.r_fmt.func inside {fetch_pkg::FN_SLL, fetch_pkg::FN_SRL,
                fetch_pkg::FN_SRA, fetch_pkg::FN_SLLV, fetch_pkg::FN_SRLV,
                fetch_pkg::FN_SRAV});
            fetch_pkg::OP_BEQ,
            fetch_pkg::OP_BNE: return 1'b1;
            fetch_pkg::OP_SPECIAL2: return w.r_fmt.func == fetch_pkg::FN_MUL;
            fetch_pkg::OP_COP0: return w.r_fmt.rs == fetch_pkg::COP0_MT;
            // lwl/lwr merge into rt, stores 0x28..0x2f
            default: return (w.i_fmt.op inside {fetch_pkg::OP_LWL, fetch_pkg::OP_LWR}) ||
                (w.i_fmt.op[5:3] == 3'b101);
        endcase
    endfunction

    fetch_pkg::inst_word_u inst0;
    fetch_pkg::inst_word_u inst1;
    logic [4:0]            dest0;
    logic                  raw_hazard;
    logic                  single_issue;

    assign inst0 = head0_inst;
    assign inst1 = head1_inst;

    // mfhi/mflo write rd, the other load types write rt
    assign dest0 = (inst0.r_fmt.op == fetch_pkg::OP_SPECIAL) ? inst0.r_fmt.rd : inst0.i_fmt.rt;

    assign raw_hazard = is_load(inst0) && (dest0 != 5'd0) &&
                        ((reads_rs(inst1) && (inst1.i_fmt.rs == dest0)) ||
                         (reads_rt(inst1) && (inst1.i_fmt.rt == dest0)));

    assign single_issue = is_branch(inst1) || (is_muldiv(inst0) && is_muldiv(inst1)) ||
                          raw_hazard;

    assign issue_valid = head_valid;
    assign issue_dual  = !single_issue;
    assign pop_en      = issue_valid && issue_ready;
    assign pop_two     = issue_dual;

    assign slot0_inst  = head0_inst;
    assign slot0_pc    = head0_pc;
    assign slot0_fault = head0_fault;

    // second slot reads as zero when held back
    assign slot1_inst  = issue_dual ? head1_inst : '0;
    assign slot1_pc    = issue_dual ? head1_pc : '0;
    assign slot1_fault = issue_dual && head1_fault;

endmodule

/* inst_queue.sv */
module inst_queue #(
    parameter int LINE_WORDS  = 8,
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  flush,
    input  logic                                  push_en,
    input  logic [$clog2(LINE_WORDS + 1)-1:0]     push_count,
    input  fetch_pkg::word_t [LINE_WORDS-1:0]     push_data,
    input  fetch_pkg::pc_t                        push_pc,
    input  logic                                  push_fault,
    input  logic                                  pop_en,
    input  logic                                  pop_two,
    output logic                                  has_room,
    output logic                                  head_valid,
    output fetch_pkg::word_t                      head0_inst,
    output fetch_pkg::pc_t                        head0_pc,
    output logic                                  head0_fault,
    output fetch_pkg::word_t                      head1_inst,
    output fetch_pkg::pc_t                        head1_pc,
    output logic                                  head1_fault
);

    localparam int AW = $clog2(QUEUE_DEPTH);

    fetch_pkg::word_t inst_mem  [QUEUE_DEPTH];
    fetch_pkg::pc_t   pc_mem    [QUEUE_DEPTH];
    logic             fault_mem [QUEUE_DEPTH];

    logic [AW-1:0] head_q;
    logic [AW-1:0] tail_q;
    logic [AW-1:0] head1_idx;
    logic [AW-1:0] level;

    // pointers wrap, level never reaches QUEUE_DEPTH
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (push_en) begin
                tail_q <= tail_q + AW'(push_count);
            end
            if (pop_en) begin
                head_q <= head_q + (pop_two ? AW'(2) : AW'(1));
            end
        end
    end

    // up to a whole line lands at the tail in one edge
    always_ff @(posedge clk) begin
        if (push_en && !flush) begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                if (i < int'(push_count)) begin
                    inst_mem[tail_q + AW'(i)]  <= push_data[i];
                    pc_mem[tail_q + AW'(i)]    <= push_pc +
                        fetch_pkg::pc_t'(i * fetch_pkg::INST_BYTES);
                    fault_mem[tail_q + AW'(i)] <= push_fault;
                end
            end
        end
    end

    assign level     = tail_q - head_q;
    assign head1_idx = head_q + AW'(1);

    // room for a full line after this one
    assign has_room   = level <= AW'(QUEUE_DEPTH / 2 - 1);
    assign head_valid = !flush && (level >= AW'(2));

    assign head0_inst  = inst_mem[head_q];
    assign head0_pc    = pc_mem[head_q];
    assign head0_fault = fault_mem[head_q];
    assign head1_inst  = inst_mem[head1_idx];
    assign head1_pc    = pc_mem[head1_idx];
    assign head1_fault = fault_mem[head1_idx];

endmodule

/* fetch_line_receiver.sv */
module fetch_line_receiver #(
    parameter int LINE_WORDS = 8
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  flush,
    input  logic                                  pc_valid,
    input  fetch_pkg::pc_t                        pc,
    input  logic                                  pc_fault,
    input  logic                                  line_ok,
    input  logic [$clog2(LINE_WORDS + 1)-1:0]     line_count,
    input  fetch_pkg::word_t [LINE_WORDS-1:0]     line_data,
    input  logic                                  has_room,
    output logic                                  pc_ready,
    output logic [5:0]                            pc_offset,
    output logic                                  push_en,
    output logic [$clog2(LINE_WORDS + 1)-1:0]     push_count,
    output fetch_pkg::word_t [LINE_WORDS-1:0]     push_data,
    output fetch_pkg::pc_t                        push_pc,
    output logic                                  push_fault
);

    localparam int CW = $clog2(LINE_WORDS + 1);

    fetch_pkg::recv_state_t state_q;
    fetch_pkg::recv_state_t state_next;
    fetch_pkg::pc_t         pc_q;
    logic                   fetch_acc;
    logic                   line_take;

    // new address only when idle and a whole line is sure to fit
    assign pc_ready  = (state_q == fetch_pkg::WAIT_PC) && has_room;
    assign fetch_acc = pc_valid && pc_ready;
    assign line_take = (state_q == fetch_pkg::RECV_LINE) && line_ok;

    always_comb begin
        state_next = state_q;
        case (state_q)
            fetch_pkg::WAIT_PC: begin
                if (fetch_acc) begin
                    state_next = pc_fault ? fetch_pkg::RECV_FAULT : fetch_pkg::RECV_LINE;
                end
            end
            fetch_pkg::RECV_LINE: begin
                if (line_ok) begin
                    state_next = fetch_pkg::WAIT_PC;
                end else if (flush) begin
                    state_next = fetch_pkg::DRAIN;
                end
            end
            fetch_pkg::RECV_FAULT: begin
                state_next = fetch_pkg::WAIT_PC;
            end
            fetch_pkg::DRAIN: begin
                // stale line still owed by the cache
                if (line_ok) begin
                    state_next = fetch_pkg::WAIT_PC;
                end
            end
            default: begin
                state_next = fetch_pkg::WAIT_PC;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= fetch_pkg::WAIT_PC;
        end else begin
            state_q <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_acc) begin
            pc_q <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            pc_offset <= 6'd4;
        end else if (line_take) begin
            pc_offset <= 6'(line_count * fetch_pkg::INST_BYTES);
        end
    end

    // fault pair is two zero words at pc and pc+4
    assign push_fault = (state_q == fetch_pkg::RECV_FAULT);
    assign push_en    = line_take || push_fault;
    assign push_count = push_fault ? CW'(2) : line_count;
    assign push_data  = push_fault ? '0 : line_data;
    assign push_pc    = pc_q;

endmodule

/* fetch_pkg.sv */
package fetch_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;

    // byte step between consecutive queue entries
    localparam int unsigned INST_BYTES = 4;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_REGIMM   = 6'h01;
    localparam logic [5:0] OP_J        = 6'h02;
    localparam logic [5:0] OP_JAL      = 6'h03;
    localparam logic [5:0] OP_BEQ      = 6'h04;
    localparam logic [5:0] OP_BNE      = 6'h05;
    localparam logic [5:0] OP_BLEZ     = 6'h06;
    localparam logic [5:0] OP_BGTZ     = 6'h07;
    localparam logic [5:0] OP_LUI      = 6'h0f;
    localparam logic [5:0] OP_COP0     = 6'h10;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;
    localparam logic [5:0] OP_LB       = 6'h20;
    localparam logic [5:0] OP_LH       = 6'h21;
    localparam logic [5:0] OP_LWL      = 6'h22;
    localparam logic [5:0] OP_LW       = 6'h23;
    localparam logic [5:0] OP_LBU      = 6'h24;
    localparam logic [5:0] OP_LHU      = 6'h25;
    localparam logic [5:0] OP_LWR      = 6'h26;

    // SPECIAL function codes, FN_MUL sits under SPECIAL2
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_MUL   = 6'h02;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_SRA   = 6'h03;
    localparam logic [5:0] FN_SLLV  = 6'h04;
    localparam logic [5:0] FN_SRLV  = 6'h06;
    localparam logic [5:0] FN_SRAV  = 6'h07;
    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_JALR  = 6'h09;
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MTHI  = 6'h11;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MTLO  = 6'h13;
    localparam logic [5:0] FN_MULT  = 6'h18;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_DIV   = 6'h1a;
    localparam logic [5:0] FN_DIVU  = 6'h1b;
    localparam logic [5:0] FN_ADDU  = 6'h21;

    // rs field of COP0 moves
    localparam logic [4:0] COP0_MF = 5'h00;
    localparam logic [4:0] COP0_MT = 5'h04;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] func;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] jidx;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } inst_word_u;

    // one-hot receive states
    typedef enum logic [3:0] {
        WAIT_PC    = 4'b0001,
        RECV_LINE  = 4'b0010,
        RECV_FAULT = 4'b0100,
        DRAIN      = 4'b1000
    } recv_state_t;

endpackage
